// File: include/ladybird_config.svh
`ifndef LADYBIRD_CONFIG_SVH
`define LADYBIRD_CONFIG_SVH

// bus word width
`define LB_XLEN 32

// word-address widths of the two memories
`define LB_IRAM_ADDR_W 4
`define LB_DRAM_ADDR_W 8

// a region matches when the address bits above its size equal its base
`define LB_IRAM_BASE 32'h0000_0000
`define LB_DRAM_BASE 32'h8000_0000

`endif

// File: ladybird_mem.f
+incdir+include
src/ladybird_pkg.sv
src/ladybird_data_ram.sv
src/ladybird_inst_ram.sv
src/ladybird_mem_router.sv
src/ladybird_mem.sv
verif/tb_clkgen.sv
verif/tb_ladybird_mem.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_ladybird_mem \
  -f ladybird_mem.f > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vtb_ladybird_mem > sim.log 2>&1 || true
cat sim.log
grep -q "TB PASSED" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: src/ladybird_data_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "ladybird_config.svh"

module ladybird_data_ram (
  input  logic                  clk,
  input  logic                  anrst,
  input  logic                  nrst,
  input  ladybird_pkg::bus_req_t req,
  output ladybird_pkg::bus_rsp_t rsp
);

  import ladybird_pkg::*;

  localparam int words = 1 << `LB_DRAM_ADDR_W;

  logic [`LB_XLEN-1:0]        mem [words];
  logic [`LB_DRAM_ADDR_W-1:0] word_addr;
  logic                       is_read;
  logic                       is_write;
  logic                       rsp_valid;
  logic [`LB_XLEN-1:0]        rdata_q;

  assign word_addr = req.addr[`LB_DRAM_ADDR_W+1:2];
  assign is_write  = req.req && (req.wstrb != '0);
  assign is_read   = req.req && (req.wstrb == '0);

  always_ff @(posedge clk, negedge anrst) begin
    if (!anrst) begin
      rsp_valid <= 1'b0;
    end else if (!nrst) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= is_read;
    end
  end

  // contents survive both resets, only the port is held off
  always_ff @(posedge clk) begin
    if (nrst && is_write) begin
      for (int b = 0; b < $bits(req.wstrb); b++) begin
        if (req.wstrb[b]) mem[word_addr][8*b +: 8] <= req.wdata[8*b +: 8];
      end
    end
    if (is_read) rdata_q <= mem[word_addr];
  end

  assign rsp = '{valid: rsp_valid, err: 1'b0, rdata: rdata_q};

endmodule

`default_nettype wire

// File: src/ladybird_inst_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "ladybird_config.svh"

module ladybird_inst_ram (
  input  logic                  clk,
  input  logic                  anrst,
  input  logic                  nrst,
  input  ladybird_pkg::bus_req_t req,
  output ladybird_pkg::bus_rsp_t rsp
);

  import ladybird_pkg::*;

  localparam int words = 1 << `LB_IRAM_ADDR_W;

  logic [`LB_XLEN-1:0]        mem [words];
  logic [`LB_IRAM_ADDR_W-1:0] word_addr;
  logic                       is_read;
  logic                       is_write;
  logic                       rsp_valid;
  logic [`LB_XLEN-1:0]        rdata_q;

  // boot program, everything past the jump is a nop
  function automatic logic [`LB_XLEN-1:0] boot_word(input int unsigned idx);
    case (idx)
      0:       return enc_lui(5'd1, 20'hfffff);
      1:       return enc_srai(5'd1, 5'd1, 5'd12);
      2:       return enc_lb(5'd2, 12'h000, 5'd1);
      3:       return enc_lui(5'd3, 20'h90000);
      4:       return enc_lw(5'd4, 12'h000, 5'd3);
      5:       return enc_addi(5'd5, 5'd4, 12'h001);
      6:       return enc_lui(5'd6, 20'h80000);
      7:       return enc_sw(5'd5, 12'h000, 5'd6);
      8:       return enc_lw(5'd7, 12'h000, 5'd6);
      9:       return enc_lui(5'd8, 20'he0000);
      10:      return enc_addi(5'd8, 5'd8, 12'h008);
      11:      return enc_sb(5'd2, 12'h000, 5'd8);
      12:      return enc_sb(5'd7, 12'h000, 5'd1);
      13:      return enc_j(-21'd44);
      default: return enc_nop();
    endcase
  endfunction

  assign word_addr = req.addr[`LB_IRAM_ADDR_W+1:2];
  assign is_write  = req.req && (req.wstrb != '0);
  assign is_read   = req.req && (req.wstrb == '0);

  // both resets reload the program
  always_ff @(posedge clk, negedge anrst) begin
    if (!anrst) begin
      for (int i = 0; i < words; i++) mem[i] <= boot_word(i);
      rsp_valid <= 1'b0;
    end else if (!nrst) begin
      for (int i = 0; i < words; i++) mem[i] <= boot_word(i);
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= is_read;
      if (is_write) begin
        for (int b = 0; b < $bits(req.wstrb); b++) begin
          if (req.wstrb[b]) mem[word_addr][8*b +: 8] <= req.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (is_read) rdata_q <= mem[word_addr];
  end

  assign rsp = '{valid: rsp_valid, err: 1'b0, rdata: rdata_q};

  // writes never answer
  a_no_rsp_after_write: assert property (
    @(posedge clk) disable iff (!anrst) is_write |=> !rsp.valid
  );

endmodule

`default_nettype wire

// File: src/ladybird_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "ladybird_config.svh"

module ladybird_mem (
  input  logic                  clk,
  input  logic                  anrst,
  input  logic                  nrst,
  input  ladybird_pkg::bus_req_t cpu_req,
  output ladybird_pkg::bus_rsp_t cpu_rsp
);

  import ladybird_pkg::*;

  bus_req_t iram_req;
  bus_req_t dram_req;
  bus_rsp_t iram_rsp;
  bus_rsp_t dram_rsp;

  ladybird_mem_router u_router (
    .clk      (clk),
    .anrst    (anrst),
    .nrst     (nrst),
    .cpu_req  (cpu_req),
    .iram_rsp (iram_rsp),
    .dram_rsp (dram_rsp),
    .iram_req (iram_req),
    .dram_req (dram_req),
    .cpu_rsp  (cpu_rsp)
  );

  ladybird_inst_ram u_iram (
    .clk   (clk),
    .anrst (anrst),
    .nrst  (nrst),
    .req   (iram_req),
    .rsp   (iram_rsp)
  );

  ladybird_data_ram u_dram (
    .clk   (clk),
    .anrst (anrst),
    .nrst  (nrst),
    .req   (dram_req),
    .rsp   (dram_rsp)
  );

endmodule

`default_nettype wire

// File: src/ladybird_mem_router.sv
`timescale 1ns/1ps
`default_nettype none

`include "ladybird_config.svh"

module ladybird_mem_router (
  input  logic                  clk,
  input  logic                  anrst,
  input  logic                  nrst,
  input  ladybird_pkg::bus_req_t cpu_req,
  input  ladybird_pkg::bus_rsp_t iram_rsp,
  input  ladybird_pkg::bus_rsp_t dram_rsp,
  output ladybird_pkg::bus_req_t iram_req,
  output ladybird_pkg::bus_req_t dram_req,
  output ladybird_pkg::bus_rsp_t cpu_rsp
);

  import ladybird_pkg::*;

  localparam int                  iram_lsb  = `LB_IRAM_ADDR_W + 2;
  localparam int                  dram_lsb  = `LB_DRAM_ADDR_W + 2;
  localparam logic [`LB_XLEN-1:0] iram_base = `LB_IRAM_BASE;
  localparam logic [`LB_XLEN-1:0] dram_base = `LB_DRAM_BASE;

  // which source owns next cycle's response
  typedef enum logic [1:0] {
    SEL_NONE,
    SEL_IRAM,
    SEL_DRAM,
    SEL_ERR
  } sel_t;

  logic hit_iram;
  logic hit_dram;
  logic is_read;
  logic needs_rsp;
  sel_t sel_d;
  sel_t sel_q;

  assign hit_iram  = cpu_req.addr[`LB_XLEN-1:iram_lsb] == iram_base[`LB_XLEN-1:iram_lsb];
  assign hit_dram  = cpu_req.addr[`LB_XLEN-1:dram_lsb] == dram_base[`LB_XLEN-1:dram_lsb];
  assign is_read   = cpu_req.wstrb == '0;
  assign needs_rsp = cpu_req.req && (is_read || !(hit_iram || hit_dram));

  always_comb begin
    iram_req     = cpu_req;
    dram_req     = cpu_req;
    iram_req.req = cpu_req.req && hit_iram;
    dram_req.req = cpu_req.req && hit_dram;
  end

  always_comb begin
    if (!cpu_req.req)   sel_d = SEL_NONE;
    else if (hit_iram)  sel_d = is_read ? SEL_IRAM : SEL_NONE;
    else if (hit_dram)  sel_d = is_read ? SEL_DRAM : SEL_NONE;
    else                sel_d = SEL_ERR;
  end

  always_ff @(posedge clk, negedge anrst) begin
    if (!anrst) begin
      sel_q <= SEL_NONE;
    end else if (!nrst) begin
      sel_q <= SEL_NONE;
    end else begin
      sel_q <= sel_d;
    end
  end

  always_comb begin
    case (sel_q)
      SEL_IRAM: cpu_rsp = iram_rsp;
      SEL_DRAM: cpu_rsp = dram_rsp;
      SEL_ERR:  cpu_rsp = '{valid: 1'b1, err: 1'b1, rdata: '0};
      default:  cpu_rsp = '0;
    endcase
  end

  a_one_target: assert property (
    @(posedge clk) disable iff (!anrst) !(iram_req.req && dram_req.req)
  );

  // ties the merged response back to the request one cycle earlier
  a_rsp_has_cause: assert property (
    @(posedge clk) disable iff (!anrst) cpu_rsp.valid == $past(needs_rsp && nrst && anrst)
  );

endmodule

`default_nettype wire

// File: src/ladybird_pkg.sv
`default_nettype none

`include "ladybird_config.svh"

package ladybird_pkg;

  // any strobe set means write, no strobes means read
  typedef struct packed {
    logic                req;
    logic [`LB_XLEN-1:0] addr;
    logic [3:0]          wstrb;
    logic [`LB_XLEN-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic                valid;
    logic                err;
    logic [`LB_XLEN-1:0] rdata;
  } bus_rsp_t;

  // major opcodes used by the boot program
  typedef enum logic [6:0] {
    LUI    = 7'b0110111,
    OP_IMM = 7'b0010011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    JAL    = 7'b1101111
  } opcode_t;

  function automatic logic [`LB_XLEN-1:0] enc_lui(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, LUI};
  endfunction

  function automatic logic [`LB_XLEN-1:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                                   input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, OP_IMM};
  endfunction

  // arithmetic shift, funct7 carries bit 30
  function automatic logic [`LB_XLEN-1:0] enc_srai(input logic [4:0] rd, input logic [4:0] rs1,
                                                   input logic [4:0] shamt);
    return {7'b0100000, shamt, rs1, 3'b101, rd, OP_IMM};
  endfunction

  function automatic logic [`LB_XLEN-1:0] enc_lb(input logic [4:0] rd, input logic [11:0] imm,
                                                 input logic [4:0] rs1);
    return {imm, rs1, 3'b000, rd, LOAD};
  endfunction

  function automatic logic [`LB_XLEN-1:0] enc_lw(input logic [4:0] rd, input logic [11:0] imm,
                                                 input logic [4:0] rs1);
    return {imm, rs1, 3'b010, rd, LOAD};
  endfunction

  function automatic logic [`LB_XLEN-1:0] enc_sb(input logic [4:0] rs2, input logic [11:0] imm,
                                                 input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b000, imm[4:0], STORE};
  endfunction

  function automatic logic [`LB_XLEN-1:0] enc_sw(input logic [4:0] rs2, input logic [11:0] imm,
                                                 input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};
  endfunction

  // jal x0, the offset is scrambled into the j-type layout
  function automatic logic [`LB_XLEN-1:0] enc_j(input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd0, JAL};
  endfunction

  // addi x0, x0, 0
  function automatic logic [`LB_XLEN-1:0] enc_nop();
    return enc_addi(5'd0, 5'd0, 12'h000);
  endfunction

endpackage

`default_nettype wire

// File: verif/ladybird_mem_stimulus.txt
# columns op addr strb wdata err rdata in hex with err and rdata as the expected response
# op R read W write I idle N nrst pulse and a write answers only when err is 1
R 00000000 0 00000000 0 fffff0b7
R 00000004 0 00000000 0 40c0d093
R 00000008 0 00000000 0 00008103
R 0000000c 0 00000000 0 900001b7
R 00000010 0 00000000 0 0001a203
R 00000014 0 00000000 0 00120293
R 00000018 0 00000000 0 80000337
R 0000001c 0 00000000 0 00532023
R 00000020 0 00000000 0 00032383
R 00000024 0 00000000 0 e0000437
R 00000028 0 00000000 0 00840413
R 0000002c 0 00000000 0 00240023
R 00000030 0 00000000 0 00708023
R 00000034 0 00000000 0 fd5ff06f
R 00000038 0 00000000 0 00000013
R 0000003c 0 00000000 0 00000013
W 80000000 f 01234567 0 00000000
W 80000010 f 11223344 0 00000000
W 80000010 5 aabbccdd 0 00000000
R 80000010 0 00000000 0 11bb33dd
W 80000010 8 ee000000 0 00000000
R 80000010 0 00000000 0 eebb33dd
W 00000014 3 0000beef 0 00000000
R 00000014 0 00000000 0 0012beef
N 00000000 0 00000000 0 00000000
R 00000014 0 00000000 0 00120293
R 40000000 0 00000000 1 00000000
W 00000040 f deadbeef 1 00000000
W 80000400 f cafef00d 1 00000000
I 00000000 0 00000000 0 00000000
R 00000000 0 00000000 0 fffff0b7
R 80000000 0 00000000 0 01234567
R 00000034 0 00000000 0 fd5ff06f
R 80000010 0 00000000 0 eebb33dd

// File: verif/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
  output logic clk
);

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

endmodule

`default_nettype wire

// File: verif/tb_ladybird_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "ladybird_config.svh"

module tb_ladybird_mem;

  import ladybird_pkg::*;

  localparam int dram_words  = 1 << `LB_DRAM_ADDR_W;
  localparam int rsp_timeout = 20;
  localparam int random_ops  = 300;

  // expected response tagged with the cycle its request went out
  typedef struct packed {
    int          issue_cycle;
    logic        err;
    logic [31:0] rdata;
  } exp_rsp_t;

  logic        clk;
  logic        anrst;
  logic        nrst;
  bus_req_t    cpu_req;
  bus_rsp_t    cpu_rsp;
  exp_rsp_t    exp_q[$];
  int          cycle;
  logic [15:0] lfsr_state;
  logic [31:0] shadow [dram_words];

  tb_clkgen u_clkgen (
    .clk (clk)
  );

  ladybird_mem u_dut (
    .clk     (clk),
    .anrst   (anrst),
    .nrst    (nrst),
    .cpu_req (cpu_req),
    .cpu_rsp (cpu_rsp)
  );

  task automatic check_val(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAIL %s: got 0x%08h, expected 0x%08h", name, actual, expected);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  // a response is due exactly one cycle after its request
  task automatic collect_rsp();
    logic     due;
    exp_rsp_t exp;
    due = (exp_q.size() > 0) && (exp_q[0].issue_cycle == cycle - 1);
    check_val("cpu_rsp.valid", 32'(cpu_rsp.valid), 32'(due));
    if (due) begin
      exp = exp_q.pop_front();
      check_val("cpu_rsp.err", 32'(cpu_rsp.err), 32'(exp.err));
      check_val("cpu_rsp.rdata", cpu_rsp.rdata, exp.rdata);
    end
  endtask

  // outputs are sampled and inputs driven on the falling edge
  task automatic next_cycle();
    @(negedge clk);
    cycle++;
    collect_rsp();
  endtask

  task automatic issue(input logic [31:0] addr, input logic [3:0] strb, input logic [31:0] wdata,
                       input logic expect_rsp, input logic err, input logic [31:0] rdata);
    exp_rsp_t e;
    next_cycle();
    cpu_req = '{req: 1'b1, addr: addr, wstrb: strb, wdata: wdata};
    e.issue_cycle = cycle;
    e.err         = err;
    e.rdata       = rdata;
    if (expect_rsp) exp_q.push_back(e);
  endtask

  task automatic drive_idle();
    next_cycle();
    cpu_req = '0;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() > 0) begin
      if (waited == rsp_timeout) begin
        $display("no response from the DUT within %0d cycles", rsp_timeout);
        $display("TB FAILED");
        $fatal(1);
      end
      drive_idle();
      waited++;
    end
  endtask

  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_state[0]};
      lfsr_state = {1'b0, lfsr_state[15:1]} ^ (lfsr_state[0] ? 16'hb400 : 16'h0000);
    end
    return r;
  endfunction

  task automatic replay_file();
    int               fd;
    int               code;
    logic [7:0]       op;
    logic [8*128-1:0] skip;
    logic [31:0]      addr;
    logic [31:0]      strb;
    logic [31:0]      wdata;
    logic [31:0]      err;
    logic [31:0]      rdata;
    logic             done;
    fd = $fopen("verif/ladybird_mem_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file");
      $display("TB FAILED");
      $fatal(1);
    end
    done = 1'b0;
    while (!done) begin
      code = $fscanf(fd, "%s", op);
      if (code != 1) begin
        done = 1'b1;
      end else if (op == "#") begin
        code = $fgets(skip, fd);
      end else begin
        code = $fscanf(fd, "%h %h %h %h %h", addr, strb, wdata, err, rdata);
        if (code != 5 || !(op == "R" || op == "W" || op == "I" || op == "N")) begin
          $display("malformed line in the stimulus file");
          $display("TB FAILED");
          $fatal(1);
        end
        if (op == "N") begin
          drive_idle();
          nrst = 1'b0;
          drive_idle();
          nrst = 1'b1;
        end else if (op == "I") begin
          drive_idle();
        end else begin
          // writes only answer when they miss both memories
          issue(addr, strb[3:0], wdata, (op == "R") || err[0], err[0], rdata);
        end
      end
    end
    $fclose(fd);
  endtask

  // every data word gets a pattern built from its full word index
  task automatic fill_dram();
    logic [7:0] idx;
    for (int i = 0; i < dram_words; i++) begin
      idx       = 8'(i);
      shadow[i] = {idx ^ 8'hd0, idx, ~idx, idx ^ 8'h3c};
      issue(`LB_DRAM_BASE + 32'(i * 4), 4'hf, shadow[i], 1'b0, 1'b0, '0);
    end
  endtask

  task automatic random_traffic();
    logic [31:0]                r;
    logic [3:0]                 strb;
    logic [31:0]                wdata;
    logic [`LB_DRAM_ADDR_W-1:0] widx;
    for (int n = 0; n < random_ops; n++) begin
      strb  = 4'h0;
      wdata = '0;
      r     = rand_bits(1);
      if (r[0]) begin
        r     = rand_bits(4);
        strb  = r[3:0];
        wdata = rand_bits(32);
      end
      r    = rand_bits(`LB_DRAM_ADDR_W);
      widx = r[`LB_DRAM_ADDR_W-1:0];
      // no strobes is a read on this bus
      if (strb == 4'h0) begin
        issue(`LB_DRAM_BASE + 32'({widx, 2'b00}), 4'h0, wdata, 1'b1, 1'b0, shadow[widx]);
      end else begin
        for (int b = 0; b < 4; b++) begin
          if (strb[b]) shadow[widx][8*b +: 8] = wdata[8*b +: 8];
        end
        issue(`LB_DRAM_BASE + 32'({widx, 2'b00}), strb, wdata, 1'b0, 1'b0, '0);
      end
    end
  endtask

  initial begin
    anrst      = 1'b0;
    nrst       = 1'b1;
    cpu_req    = '0;
    cycle      = 0;
    lfsr_state = 16'd78;
    repeat (5) @(posedge clk);
    @(negedge clk);
    anrst = 1'b1;
    replay_file();
    drain();
    fill_dram();
    random_traffic();
    drain();
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire
